/* compile.f */
blur_pkg.sv
blur_if.sv
blur_cfg_wb.sv
blur_line_buffer.sv
blur_window.sv
blur_mac.sv
blur_filter.sv
blur_props.sv
blur_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := blur_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASS
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal --top-module $(TOP)
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* blur_tb.sv */
`default_nettype none

module blur_tb
    import blur_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMG_W       = 15;
    localparam int ROWS        = 8;
    localparam int FRAME_PIX   = IMG_W * ROWS;
    localparam int WB_LIMIT    = 20;   // Cycles to wait for ack
    localparam int DRAIN_LIMIT = 100;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        pix_valid;
    logic        pix_sof;
    pixel_t      pix_data;
    logic        pix_out_valid;
    pixel_t      pix_out_data;

    pixel_t      frame_mem [ROWS][IMG_W];  // Copy of the frame being sent
    pixel_t      exp_q [$];
    int unsigned stamp_q [$];                // Edge at which each pixel is accepted
    int unsigned tick;
    pixel_t      exp_pix;
    int unsigned stamp;
    logic [31:0] rng_state;
    logic [31:0] rd;
    string       test_name;
    int          err_value;
    int          err_latency;
    int          err_other;

    blur_filter #(.IMG_WIDTH(IMG_W)) u_dut (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .pix_valid     (pix_valid),
        .pix_sof       (pix_sof),
        .pix_data      (pix_data),
        .pix_out_valid (pix_out_valid),
        .pix_out_data  (pix_out_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Window ends at (row, col); incomplete windows pass the pixel
    function automatic pixel_t ref_pixel(input int row, input int col, input kernel_sel_t k);
        int side;
        int acc;
        int w;
        side = (k == KSEL_3X3) ? 3 : ((k == KSEL_5X5) ? 5 : 1);
        if (side == 1 || row < side - 1 || col < side - 1) begin
            return frame_mem[row][col];
        end
        acc = 0;
        for (int r = 0; r < side; r++) begin
            for (int c = 0; c < side; c++) begin
                w = (side == 3) ? int'(weights_3[r][c]) : int'(weights_5[r][c]);
                acc = acc + w * int'(frame_mem[row - side + 1 + r][col - side + 1 + c]);
            end
        end
        return (side == 3) ? pixel_t'(acc >> 5) : pixel_t'(acc >> 6);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s expected %0d actual %0d", what, expected, actual);
            err_value++;
        end
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int  waited;
        logic seen;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < WB_LIMIT) begin
            @(negedge clk);
            seen = wb_ack;
            waited++;
        end
        rdata = wb_dat_r;  // Valid while ack is high
        if (!seen) begin
            $display("Wishbone access to address %0d got no ack within %0d cycles",
                     adr, WB_LIMIT);
            err_other++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused_rd;
        wb_access(1'b1, adr, data, unused_rd);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'd0, data);
    endtask

    // Fills a frame, then drives it pixel by pixel with optional idle gaps
    task automatic send_frame(input kernel_sel_t k, input bit gaps, input bit flat);
        int gap_len;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                rng_state = lcg_step(rng_state);
                frame_mem[r][c] = flat ? 12'hfff : rng_state[27:16];
            end
        end
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                @(posedge clk);
                pix_valid <= 1'b1;
                pix_sof   <= (r == 0 && c == 0);
                pix_data  <= frame_mem[r][c];
                exp_q.push_back(ref_pixel(r, c, k));
                gap_len = 0;
                if (gaps) begin
                    rng_state = lcg_step(rng_state);
                    gap_len = int'(rng_state[31:30]);
                end
                for (int g = 0; g < gap_len; g++) begin
                    @(posedge clk);
                    pix_valid <= 1'b0;
                    pix_sof   <= 1'b0;
                end
            end
        end
        @(posedge clk);
        pix_valid <= 1'b0;
        pix_sof   <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d output pixels never arrived", test_name, exp_q.size());
            err_other++;
        end
    endtask

    // Compare process samples on the falling edge where outputs are stable
    always @(negedge clk) begin
        tick = tick + 1;
        if (!rst && pix_valid) begin
            stamp_q.push_back(tick + 1);  // Accepted at the next rising edge
        end
        if (!rst && pix_out_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: output pixel %0d appeared with none pending", test_name,
                         pix_out_data);
                err_other++;
            end else begin
                exp_pix = exp_q.pop_front();
                stamp   = stamp_q.pop_front();
                assert (pix_out_data === exp_pix) else begin
                    $display("error %s expected %0d actual %0d", test_name, exp_pix,
                             pix_out_data);
                    err_value++;
                end
                assert (tick - stamp == 2) else begin
                    $display("error %s latency expected 2 actual %0d", test_name,
                             tick - stamp);
                    err_latency++;
                end
            end
        end
    end

    initial begin
        rst         = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 2'd0;
        wb_dat_w    = 32'd0;
        pix_valid   = 1'b0;
        pix_sof     = 1'b0;
        pix_data    = '0;
        tick        = 0;
        rng_state   = 32'hd76768a2;
        err_value   = 0;
        err_latency = 0;
        err_other   = 0;
        test_name   = "reset";
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        test_name = "ctrl_readback";
        for (int v = 3; v >= 0; v--) begin
            wb_write(ADDR_CTRL, 32'(v));
            wb_read(ADDR_CTRL, rd);
            check_value(test_name, 32'(v), rd);
        end

        wb_write(ADDR_COUNT, 32'd0);
        test_name = "pass_1x1";
        send_frame(KSEL_1X1, 1'b0, 1'b0);
        drain();
        test_name = "count";
        wb_read(ADDR_COUNT, rd);
        check_value(test_name, 32'(FRAME_PIX), rd);
        wb_write(ADDR_COUNT, 32'd0);
        wb_read(ADDR_COUNT, rd);
        check_value("count_clear", 32'd0, rd);

        test_name = "blur_3x3";
        wb_write(ADDR_CTRL, 32'(KSEL_3X3));
        send_frame(KSEL_3X3, 1'b0, 1'b0);
        drain();

        test_name = "flat_5x5";
        wb_write(ADDR_CTRL, 32'(KSEL_5X5));
        send_frame(KSEL_5X5, 1'b0, 1'b1);
        drain();
        test_name = "blur_5x5";
        send_frame(KSEL_5X5, 1'b0, 1'b0);
        drain();

        // Kernel change lands mid-frame and must wait for the next sof
        test_name = "switch_mid_frame";
        wb_write(ADDR_CTRL, 32'(KSEL_3X3));
        fork
            send_frame(KSEL_3X3, 1'b0, 1'b0);
            begin
                repeat (40) @(posedge clk);
                wb_write(ADDR_CTRL, 32'(KSEL_5X5));
            end
        join
        send_frame(KSEL_5X5, 1'b1, 1'b0);  // Idle gaps between pixels
        drain();

        $display("errors: value %0d latency %0d other %0d", err_value, err_latency, err_other);
        if (err_value + err_latency + err_other == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* blur_props.sv */
`default_nettype none

module blur_props
    import blur_pkg::*;
(
    input wire logic   clk,
    input wire logic   rst,
    input wire logic   wb_cyc,
    input wire logic   wb_stb,
    input wire logic   wb_ack,
    input wire logic   pix_valid,
    input wire logic   pix_sof,
    input wire logic   pix_out_valid,
    input wire pixel_t pix_out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic active;  // A frame has started since reset
    logic accept;

    assign accept = pix_valid && (pix_sof || active);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (pix_valid && pix_sof) begin
            active <= 1'b1;
        end
    end

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for more than one cycle");

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_cyc && wb_stb)
        else $error("wb_ack raised outside a bus cycle");

    // Output valid is registered two edges after the accepting edge,
    // so it is first sampled high at the third edge
    out_latency: assert property (@(posedge clk) disable iff (rst)
        pix_out_valid == $past(accept, 3))
        else $error("pix_out_valid does not follow an accepted pixel by two cycles");

    out_known: assert property (@(posedge clk) disable iff (rst)
        pix_out_valid |-> !$isunknown(pix_out_data))
        else $error("pix_out_data unknown while valid");

endmodule

bind blur_filter blur_props u_props (
    .clk           (clk),
    .rst           (rst),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_ack        (wb_ack),
    .pix_valid     (pix_valid),
    .pix_sof       (pix_sof),
    .pix_out_valid (pix_out_valid),
    .pix_out_data  (pix_out_data)
);

`default_nettype wire

/* blur_filter.sv */
`default_nettype none

module blur_filter
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH = 15  // Pixels per row, up to 320
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [1:0]  wb_adr,
    input  wire logic [31:0] wb_dat_w,
    output logic      [31:0] wb_dat_r,
    output logic             wb_ack,
    input  wire logic        pix_valid,
    input  wire logic        pix_sof,
    input  wire pixel_t      pix_data,
    output logic             pix_out_valid,
    output pixel_t           pix_out_data
);

    kernel_sel_t ksel;

    col_if col_bus ();
    win_if win_bus ();

    blur_cfg_wb u_cfg (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .out_pulse (pix_out_valid),  // One count per output pixel
        .ksel      (ksel)
    );

    // Pixel path takes two cycles from input to output
    blur_line_buffer #(.IMG_WIDTH(IMG_WIDTH)) u_lbuf (
        .clk       (clk),
        .rst       (rst),
        .pix_valid (pix_valid),
        .pix_sof   (pix_sof),
        .pix_data  (pix_data),
        .ksel      (ksel),
        .col       (col_bus.src)
    );

    blur_window u_win (.clk(clk), .rst(rst), .col(col_bus.dst), .win(win_bus.src));

    blur_mac u_mac (
        .clk           (clk),
        .rst           (rst),
        .win           (win_bus.dst),
        .pix_out_valid (pix_out_valid),
        .pix_out_data  (pix_out_data)
    );

endmodule

`default_nettype wire

/* blur_mac.sv */
`default_nettype none

module blur_mac
    import blur_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    win_if.dst        win,
    output logic      pix_out_valid,
    output pixel_t    pix_out_data
);

    localparam int SHIFT_3 = 5;          // Divide by 32
    localparam int SHIFT_5 = 6;          // Divide by 64
    localparam int OFS_3   = MAX_K - 3;  // 3x3 sits in the lower-right corner

    acc_t   sum3;
    acc_t   sum5;
    pixel_t result;

    always_comb begin
        sum3 = '0;
        sum5 = '0;

        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                sum3 = sum3 + acc_t'(win.taps[r+OFS_3][c+OFS_3]) * acc_t'(weights_3[r][c]);
            end
        end

        for (int r = 0; r < MAX_K; r++) begin
            for (int c = 0; c < MAX_K; c++) begin
                sum5 = sum5 + acc_t'(win.taps[r][c]) * acc_t'(weights_5[r][c]);
            end
        end

        // Incomplete windows leave the pixel unchanged
        if (!win.complete) begin
            result = win.center;
        end else begin
            case (win.sel)
                KSEL_3X3: result = pixel_t'(sum3 >> SHIFT_3);
                KSEL_5X5: result = pixel_t'(sum5 >> SHIFT_5);
                default:  result = win.center;  // 1x1 and the unused code
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_out_valid <= 1'b0;
        end else begin
            pix_out_valid <= win.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win.valid) begin
            pix_out_data <= result;
        end
    end

endmodule

`default_nettype wire

/* blur_window.sv */
`default_nettype none

module blur_window
    import blur_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    col_if.dst        col,
    win_if.src        win
);

    pixel_t tap_q [MAX_K][MAX_K];  // [row][col], column MAX_K-1 is the newest

    // Shift left and load the new column on the right
    // Idle cycles hold the window so gaps do not disturb it
    always_ff @(posedge clk) begin
        if (col.valid) begin
            for (int r = 0; r < MAX_K; r++) begin
                for (int c = 0; c < MAX_K - 1; c++) begin
                    tap_q[r][c] <= tap_q[r][c+1];
                end
                tap_q[r][MAX_K-1] <= col.column[r];
            end
            win.center <= col.column[MAX_K-1];
        end
    end

    // Flags follow the taps one stage along
    always_ff @(posedge clk) begin
        if (rst) begin
            win.valid    <= 1'b0;
            win.complete <= 1'b0;
            win.sel      <= KSEL_1X1;
        end else begin
            win.valid <= col.valid;
            if (col.valid) begin
                // Windows spanning a row boundary never carry complete
                win.complete <= col.complete;
                win.sel      <= col.sel;
            end
        end
    end

    assign win.taps = tap_q;

endmodule

`default_nettype wire

/* blur_line_buffer.sv */
`default_nettype none

module blur_line_buffer
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH = 15
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        pix_valid,
    input  wire logic        pix_sof,
    input  wire pixel_t      pix_data,
    input  wire kernel_sel_t ksel,
    col_if.src               col
);

    localparam int COL_W = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;

    pixel_t           row_mem [MAX_K-1][IMG_WIDTH];  // Ring of the four previous rows
    logic [1:0]       row_ptr;                       // Slot the current row writes into
    logic [COL_W-1:0] col_cnt;
    logic [2:0]       row_cnt;                       // Saturates at MAX_K-1
    logic             frame_active;
    kernel_sel_t      frame_sel;                     // Kernel latched at sof

    logic             accept;
    logic [COL_W-1:0] cur_col;
    logic [2:0]       cur_row;
    kernel_sel_t      cur_sel;
    kernel_sel_t      ksel_norm;
    logic [2:0]       need;                          // K-1 for the frame kernel

    always_comb begin
        ksel_norm = (ksel == KSEL_3X3 || ksel == KSEL_5X5) ? ksel : KSEL_1X1;
        accept    = pix_valid && (pix_sof || frame_active);  // Drop pixels before first sof
        cur_col   = pix_sof ? '0 : col_cnt;
        cur_row   = pix_sof ? '0 : row_cnt;
        cur_sel   = pix_sof ? ksel_norm : frame_sel;
        case (cur_sel)
            KSEL_3X3: need = 3'd2;
            KSEL_5X5: need = 3'(MAX_K - 1);
            default:  need = 3'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_active <= 1'b0;
            frame_sel    <= KSEL_1X1;
            row_ptr      <= '0;
            col_cnt      <= '0;
            row_cnt      <= '0;
            col.valid    <= 1'b0;
            col.complete <= 1'b0;
            col.sel      <= KSEL_1X1;
        end else begin
            col.valid <= accept;
            if (accept) begin
                frame_active <= 1'b1;
                frame_sel    <= cur_sel;
                col.sel      <= cur_sel;
                col.complete <= (cur_row >= need) && (int'(cur_col) >= int'(need));
                if (cur_col == COL_W'(IMG_WIDTH - 1)) begin  // Last pixel of the row
                    col_cnt <= '0;
                    row_ptr <= row_ptr + 2'd1;
                    row_cnt <= (cur_row == 3'(MAX_K - 1)) ? cur_row : cur_row + 3'd1;
                end else begin
                    col_cnt <= cur_col + 1'b1;
                    row_cnt <= cur_row;
                end
            end
        end
    end

    // Slot row_ptr+i holds row r-4+i, read before this pixel overwrites it
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < MAX_K - 1; i++) begin
                col.column[i] <= row_mem[row_ptr + 2'(i)][cur_col];
            end
            col.column[MAX_K-1]       <= pix_data;
            row_mem[row_ptr][cur_col] <= pix_data;
        end
    end

endmodule

`default_nettype wire

/* blur_cfg_wb.sv */
`default_nettype none

module blur_cfg_wb
    import blur_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [1:0]  wb_adr,
    input  wire logic [31:0] wb_dat_w,
    output logic      [31:0] wb_dat_r,
    output logic             wb_ack,
    input  wire logic        out_pulse,
    output kernel_sel_t      ksel
);

    logic [1:0]  ctrl_q;   // Kernel select, reads back as written
    logic [31:0] count_q;  // Output pixels since reset or last clear
    logic        req;

    // New request, blocked during the ack cycle so that ack lasts one cycle
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack  <= 1'b0;
            ctrl_q  <= 2'd0;
            count_q <= '0;
        end else begin
            wb_ack <= req;

            if (req && wb_we && wb_adr == ADDR_CTRL) begin
                ctrl_q <= wb_dat_w[1:0];
            end

            // Clear on write has priority over counting
            if (req && wb_we && wb_adr == ADDR_COUNT) begin
                count_q <= '0;
            end else if (out_pulse) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    // Read data is captured with the request and held through ack
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            case (wb_adr)
                ADDR_CTRL:  wb_dat_r <= {30'd0, ctrl_q};
                ADDR_COUNT: wb_dat_r <= count_q;
                default:    wb_dat_r <= '0;
            endcase
        end
    end

    // Value 3 passes through; the pixel path maps it to 1x1
    assign ksel = kernel_sel_t'(ctrl_q);

endmodule

`default_nettype wire

/* blur_if.sv */
`default_nettype none

// One buffered column, oldest row at index 0
interface col_if import blur_pkg::*; ();
    logic        valid;
    pixel_t      column [MAX_K];
    logic        complete;  // Window ending here is full for the frame kernel
    kernel_sel_t sel;

    modport src (output valid, column, complete, sel);
    modport dst (input valid, column, complete, sel);
endinterface

// Aligned 5x5 window, taps[row][col] with [MAX_K-1][MAX_K-1] the newest pixel
interface win_if import blur_pkg::*; ();
    logic        valid;
    pixel_t      taps [MAX_K][MAX_K];
    logic        complete;
    kernel_sel_t sel;
    pixel_t      center;

    modport src (output valid, taps, complete, sel, center);
    modport dst (input valid, taps, complete, sel, center);
endinterface

`default_nettype wire

/* blur_pkg.sv */
`default_nettype none

package blur_pkg;

    localparam int PIX_W = 12;

    // One grayscale camera pixel
    typedef logic [PIX_W-1:0] pixel_t;

    // Kernel select as held in CTRL[1:0]; value 3 behaves as 1x1
    typedef enum logic [1:0] {
        KSEL_1X1 = 2'd0,
        KSEL_3X3 = 2'd1,
        KSEL_5X5 = 2'd2
    } kernel_sel_t;

    localparam int MAX_K = 5;  // Largest window side

    // Wide enough for 64 * 4095
    typedef logic [19:0] acc_t;

    // 3x3 weights, sum 32
    localparam logic [3:0] weights_3 [0:2][0:2] = '{
        '{4'd3, 4'd4, 4'd3},
        '{4'd4, 4'd4, 4'd4},
        '{4'd3, 4'd4, 4'd3}
    };

    // 5x5 weights, sum 64
    localparam logic [3:0] weights_5 [0:MAX_K-1][0:MAX_K-1] = '{
        '{4'd1, 4'd2, 4'd3, 4'd2, 4'd1},
        '{4'd2, 4'd3, 4'd4, 4'd3, 4'd2},
        '{4'd3, 4'd4, 4'd4, 4'd4, 4'd3},
        '{4'd2, 4'd3, 4'd4, 4'd3, 4'd2},
        '{4'd1, 4'd2, 4'd3, 4'd2, 4'd1}
    };

    // Wishbone word addresses
    localparam logic [1:0] ADDR_CTRL  = 2'd0;
    localparam logic [1:0] ADDR_COUNT = 2'd1;

endpackage

`default_nettype wire
